//--- sources.f
src/btb_pkg.sv
src/fpga_ram.sv
src/spsram_512x54.sv
src/btb_flush.sv
src/btb_ctrl.sv
src/btb_top.sv
test/tb_btb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the BTB testbench with Verilator
# Exit status is zero only when the pass message shows up in the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_btb -f sources.f

out=$(./obj_dir/Vtb_btb)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi

//--- test/tb_btb.sv
// Self-checking testbench for the BTB top level
// Inputs change on the falling edge, outputs are sampled on the falling edge
// Every ack wait gives up after 700 cycles, enough for the post-reset flush
`timescale 1ns/100ps
`default_nettype none

module tb_btb
  import btb_pkg::*;
();

  localparam int ack_timeout = 700;
  localparam int pool_size   = 16;

  logic                 CLK = 1'b0;
  logic                 rst_n;
  logic                 req;
  logic [1:0]           op;
  logic [btb_pc_w-1:0]  pc;
  logic [btb_tgt_w-1:0] new_target;
  logic                 ack;
  logic                 hit;
  logic [btb_tgt_w-1:0] hit_target;

  // Expected SRAM contents
  btb_entry_u           model [btb_depth];
  // Expected response of the request in flight
  logic                 exp_hit;
  logic [btb_tgt_w-1:0] exp_target;
  int                   issued;
  int                   compared = 0;
  int                   cmp_errors = 0;
  int                   stim_errors;
  int                   tests;
  integer               seed;

  always #4 CLK = ~CLK;

  btb_top u_dut (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .req        (req),
    .op         (op),
    .pc         (pc),
    .new_target (new_target),
    .ack        (ack),
    .hit        (hit),
    .hit_target (hit_target)
  );

  task automatic check_bit(input string name, input logic expv, input logic got,
                           inout int errs);
    if (got !== expv) begin
      $display("error at %0d ns: %s expected %0b, got %0b", $time, name, expv, got);
      errs++;
    end
  endtask

  task automatic check_target(input string name, input logic [btb_tgt_w-1:0] expv,
                              input logic [btb_tgt_w-1:0] got, inout int errs);
    if (got !== expv) begin
      $display("error at %0d ns: %s expected %h, got %h", $time, name, expv, got);
      errs++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", ack_timeout, what);
    $display("test failed");
    $finish;
  endtask

  // Falling edges until ack reaches the level, bounded
  task automatic wait_ack(input logic level, input string what, output int cycles);
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
      if (cycles > ack_timeout) begin
        stop_on_timeout(what);
      end
    end while (ack !== level);
  endtask

  // Expected {hit, target}, writes always answer with a miss and zero
  function automatic logic [btb_tgt_w:0] ref_result(input logic [1:0] r_op,
                                                    input logic [btb_pc_w-1:0] r_pc);
    btb_entry_u e;
    logic       match;
    e     = model[r_pc[btb_idx_w+1:2]];
    match = e.fields.valid && (e.fields.tag == r_pc[btb_pc_w-1:btb_pc_w-btb_tag_w]);
    if (r_op == op_update || r_op == op_invalidate || !match) begin
      return '0;
    end
    return {1'b1, e.fields.target};
  endfunction

  task automatic model_apply(input logic [1:0] r_op, input logic [btb_pc_w-1:0] r_pc,
                             input logic [btb_tgt_w-1:0] r_tgt);
    btb_entry_u e;
    e = model[r_pc[btb_idx_w+1:2]];
    if (r_op == op_update) begin
      e.fields.valid  = 1'b1;
      e.fields.tag    = r_pc[btb_pc_w-1:btb_pc_w-btb_tag_w];
      e.fields.target = r_tgt;
    end else if (r_op == op_invalidate) begin
      // Upper half only, lower target bits survive
      e.banks.upper = '0;
    end
    model[r_pc[btb_idx_w+1:2]] = e;
  endtask

  // One full four-phase handshake
  task automatic do_request(input logic [1:0] r_op, input logic [btb_pc_w-1:0] r_pc,
                            input logic [btb_tgt_w-1:0] r_tgt, output int ack_cycles);
    int low_cycles;
    {exp_hit, exp_target} = ref_result(r_op, r_pc);
    op         = r_op;
    pc         = r_pc;
    new_target = r_tgt;
    req        = 1'b1;
    issued++;
    wait_ack(1'b1, "ack to rise", ack_cycles);
    req = 1'b0;
    wait_ack(1'b0, "ack to fall", low_cycles);
    // ack drops on the edge that sees req low
    if (low_cycles != 1) begin
      $display("ack fell %0d falling edges after req, expected 1", low_cycles);
      stim_errors++;
    end
    model_apply(r_op, r_pc, r_tgt);
  endtask

  function automatic int error_total();
    return cmp_errors + stim_errors;
  endfunction

  task automatic finish_test(input string name, input int err_before);
    int errs;
    errs = error_total() - err_before;
    tests++;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errs);
    end
  endtask

  // Compare each response once, first falling edge with ack high
  always @(negedge CLK) begin
    if (ack && compared != issued) begin
      check_bit("hit", exp_hit, hit, cmp_errors);
      check_target("hit_target", exp_target, hit_target, cmp_errors);
      compared++;
    end
  end

  initial begin
    logic [31:0]          r;
    logic [btb_pc_w-1:0]  pool_pc [pool_size];
    logic [btb_idx_w-1:0] idx_set [4];
    logic [btb_pc_w-1:0]  pc_a;
    logic [btb_pc_w-1:0]  pc_r;
    logic [btb_tgt_w-1:0] tgt_r;
    logic                 held_hit;
    logic [btb_tgt_w-1:0] held_target;
    logic [3:0]           j;
    int                   n;
    int                   err_before;
    seed        = 85691;
    rst_n       = 1'b0;
    req         = 1'b0;
    op          = op_lookup;
    pc          = '0;
    new_target  = '0;
    issued      = 0;
    stim_errors = 0;
    tests       = 0;
    for (int i = 0; i < btb_depth; i++) begin
      model[btb_idx_w'(i)] = '0;
    end
    repeat (2) @(negedge CLK);
    rst_n = 1'b1;

    // Requests issued at once must wait out the flush and miss
    err_before = error_total();
    check_bit("ack", 1'b0, ack, stim_errors);
    check_bit("hit", 1'b0, hit, stim_errors);
    check_target("hit_target", '0, hit_target, stim_errors);
    r = $random(seed);
    do_request(op_lookup, r, '0, n);
    if (n <= btb_depth) begin
      $display("ack came %0d cycles after reset, before the flush could end", n);
      stim_errors++;
    end
    repeat (4) begin
      r = $random(seed);
      do_request(op_lookup, r, '0, n);
    end
    finish_test("reset_flush", err_before);

    err_before = error_total();
    pc_a = 32'h1234_5678;
    do_request(op_update, pc_a, 32'hcafe_0010, n);
    do_request(op_lookup, pc_a, '0, n);
    // Same index, tag bit 11 flipped
    do_request(op_lookup, pc_a ^ 32'h0000_0800, '0, n);
    // pc bits 1:0 play no part
    do_request(op_lookup, pc_a ^ 32'h0000_0003, '0, n);
    finish_test("update_lookup", err_before);

    err_before = error_total();
    do_request(op_invalidate, pc_a, '0, n);
    do_request(op_lookup, pc_a, '0, n);
    do_request(op_update, pc_a, 32'h0bad_f00c, n);
    do_request(op_lookup, pc_a, '0, n);
    finish_test("invalidate", err_before);

    // Sampling edge plus two more, so ack shows on the third falling edge
    err_before = error_total();
    pc_a = 32'h8765_4320;
    do_request(op_update, pc_a, 32'h1357_9bdf, n);
    {exp_hit, exp_target} = ref_result(op_lookup, pc_a);
    op  = op_lookup;
    pc  = pc_a;
    req = 1'b1;
    issued++;
    wait_ack(1'b1, "ack to rise", n);
    if (n != 3) begin
      $display("ack rose %0d falling edges after req, expected 3", n);
      stim_errors++;
    end
    held_hit    = hit;
    held_target = hit_target;
    // Requester stalls, ack and result must hold
    repeat (4) begin
      @(negedge CLK);
      check_bit("ack", 1'b1, ack, stim_errors);
      check_bit("hit", held_hit, hit, stim_errors);
      check_target("hit_target", held_target, hit_target, stim_errors);
    end
    req = 1'b0;
    @(negedge CLK);
    check_bit("ack", 1'b0, ack, stim_errors);
    check_bit("hit", held_hit, hit, stim_errors);
    check_target("hit_target", held_target, hit_target, stim_errors);
    finish_test("handshake_timing", err_before);

    // Four tags share each of four indexes
    err_before = error_total();
    idx_set[0] = 9'd7;
    idx_set[1] = 9'd130;
    idx_set[2] = 9'd300;
    idx_set[3] = 9'd511;
    for (int i = 0; i < pool_size; i++) begin
      r = $random(seed);
      pool_pc[4'(i)] = {r[btb_tag_w-1:0], idx_set[2'(i)], 2'b00};
    end
    repeat (300) begin
      r     = $random(seed);
      j     = r[3:0];
      pc_r  = {pool_pc[j][btb_pc_w-1:2], r[5:4]};
      tgt_r = $random(seed);
      // Op code 3 goes in too, as a lookup
      do_request(r[9:8], pc_r, tgt_r, n);
    end
    finish_test("random_mix", err_before);

    if (compared != issued) begin
      $display("%0d of %0d responses were never compared", issued - compared, issued);
      stim_errors++;
    end
    $display("tests %0d, requests %0d, errors %0d", tests, issued, error_total());
    if (error_total() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/btb_top.sv
// Direct-mapped 512-entry branch target buffer
// Requests are ignored until the post-reset flush has finished
// hit and hit_target are only meaningful while ack is high
`timescale 1ns/100ps
`default_nettype none

module btb_top
  import btb_pkg::*;
(
  input  logic                 CLK,
  input  logic                 rst_n,
  input  logic                 req,
  input  logic [1:0]           op,
  input  logic [btb_pc_w-1:0]  pc,
  input  logic [btb_tgt_w-1:0] new_target,
  output logic                 ack,
  output logic                 hit,
  output logic [btb_tgt_w-1:0] hit_target
);

  logic                  flush_busy;
  logic [btb_idx_w-1:0]  flush_idx;
  logic                  cen;
  logic                  gwen;
  logic [btb_word_w-1:0] wen;
  logic [btb_idx_w-1:0]  addr;
  logic [btb_word_w-1:0] d;
  logic [btb_word_w-1:0] q;

  btb_ctrl u_ctrl (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .req        (req),
    .op         (op),
    .pc         (pc),
    .new_target (new_target),
    .ack        (ack),
    .hit        (hit),
    .hit_target (hit_target),
    .flush_busy (flush_busy),
    .flush_idx  (flush_idx),
    .cen        (cen),
    .gwen       (gwen),
    .wen        (wen),
    .addr       (addr),
    .d          (d),
    .q          (q)
  );

  btb_flush u_flush (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .flush_busy (flush_busy),
    .flush_idx  (flush_idx)
  );

  spsram_512x54 u_sram (
    .CLK  (CLK),
    .cen  (cen),
    .gwen (gwen),
    .wen  (wen),
    .addr (addr),
    .d    (d),
    .q    (q)
  );

endmodule

`default_nettype wire

//--- src/btb_ctrl.sv
// BTB request controller on a four-phase req/ack port
// One request in flight, ack two edges after req is first sampled
// Requester must hold op, pc and new_target stable while req is high
// SRAM controls are registered, flush sequencer has priority in idle
`timescale 1ns/100ps
`default_nettype none

module btb_ctrl
  import btb_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic [1:0]            op,
  input  logic [btb_pc_w-1:0]   pc,
  input  logic [btb_tgt_w-1:0]  new_target,
  output logic                  ack,
  output logic                  hit,
  output logic [btb_tgt_w-1:0]  hit_target,
  input  logic                  flush_busy,
  input  logic [btb_idx_w-1:0]  flush_idx,
  output logic                  cen,
  output logic                  gwen,
  output logic [btb_word_w-1:0] wen,
  output logic [btb_idx_w-1:0]  addr,
  output logic [btb_word_w-1:0] d,
  input  logic [btb_word_w-1:0] q
);

  logic [1:0]           state;
  logic                 is_update;
  logic                 is_inval;
  logic                 is_lookup;
  logic [btb_idx_w-1:0] req_idx;
  logic [btb_tag_w-1:0] req_tag;
  logic                 tag_match;
  btb_entry_u           rd_entry;
  btb_entry_u           wr_entry;
  btb_entry_u           wr_mask;

  // Opcode decode, anything unknown is a lookup
  assign is_update = (op == op_update);
  assign is_inval  = (op == op_invalidate);
  assign is_lookup = !is_update && !is_inval;

  // pc[10:2] selects the entry, pc[31:11] is the tag
  assign req_idx = pc[btb_idx_w+1:2];
  assign req_tag = pc[btb_pc_w-1:btb_pc_w-btb_tag_w];

  assign rd_entry  = q;
  assign tag_match = rd_entry.fields.valid && (rd_entry.fields.tag == req_tag);

  // Write word and active-low bank mask for the current op
  always_comb begin
    wr_entry = '0;
    wr_mask  = '1;
    if (flush_busy || is_inval) begin
      // Upper bank only, clears valid together with the tag
      wr_mask.banks.upper = '0;
    end else if (is_update) begin
      wr_entry.fields.valid  = 1'b1;
      wr_entry.fields.tag    = req_tag;
      wr_entry.fields.target = new_target;
      wr_mask                = '0;
    end
  end

  // Handshake FSM and SRAM strobes
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      ack        <= 1'b0;
      hit        <= 1'b0;
      hit_target <= '0;
      cen        <= 1'b1;
      gwen       <= 1'b1;
      wen        <= '1;
    end else begin
      // Deselected unless a branch below starts an access
      cen  <= 1'b1;
      gwen <= 1'b1;
      wen  <= '1;
      case (state)
        st_idle: begin
          if (flush_busy) begin
            // Flush owns the port, requests wait
            cen  <= 1'b0;
            gwen <= 1'b0;
            wen  <= wr_mask;
          end else if (req) begin
            cen   <= 1'b0;
            gwen  <= is_lookup;
            wen   <= wr_mask;
            state <= st_access;
          end
        end
        st_access: begin
          // SRAM samples the access at this edge
          state <= st_respond;
        end
        st_respond: begin
          ack        <= 1'b1;
          hit        <= is_lookup && tag_match;
          hit_target <= (is_lookup && tag_match) ? rd_entry.fields.target : '0;
          state      <= st_wait;
        end
        st_wait: begin
          // Hold ack until the requester lets go
          if (!req) begin
            ack   <= 1'b0;
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Address and write data, qualified by cen
  always_ff @(posedge CLK) begin
    if (state == st_idle) begin
      if (flush_busy) begin
        addr <= flush_idx;
        d    <= '0;
      end else begin
        addr <= req_idx;
        d    <= wr_entry;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/btb_flush.sv
// Post-reset sweep over every BTB index
// Runs once per reset, one index per cycle, 512 cycles
// Controller must give the SRAM port to this block while flush_busy is high
`timescale 1ns/100ps
`default_nettype none

module btb_flush
  import btb_pkg::*;
(
  input  logic                 CLK,
  input  logic                 rst_n,
  output logic                 flush_busy,
  output logic [btb_idx_w-1:0] flush_idx
);

  logic last_idx;

  assign last_idx = (flush_idx == btb_idx_w'(btb_depth - 1));

  // Index 0 is presented from reset, advance on every edge after it
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      flush_busy <= 1'b1;
      flush_idx  <= '0;
    end else if (flush_busy) begin
      if (last_idx) begin
        // Last index handed over, release the port
        flush_busy <= 1'b0;
      end else begin
        flush_idx <= flush_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/spsram_512x54.sv
// 512x54 single-port SRAM model built from two 27-bit banks
// Controls are active low, only wen[53] and wen[26] are honoured
// q follows the last selected address while cen is high
`timescale 1ns/100ps
`default_nettype none

module spsram_512x54
  import btb_pkg::*;
(
  input  logic                  CLK,
  input  logic                  cen,
  input  logic                  gwen,
  input  logic [btb_word_w-1:0] wen,
  input  logic [btb_idx_w-1:0]  addr,
  input  logic [btb_word_w-1:0] d,
  output logic [btb_word_w-1:0] q
);

  logic [btb_idx_w-1:0]  addr_hold;
  logic [btb_idx_w-1:0]  ram_addr;
  logic                  bank0_we;
  logic                  bank1_we;
  logic [btb_bank_w-1:0] bank0_dout;
  logic [btb_bank_w-1:0] bank1_dout;

  // Top enable bit of each half gates that bank
  assign bank0_we = !cen && !gwen && !wen[btb_bank_w-1];
  assign bank1_we = !cen && !gwen && !wen[btb_word_w-1];

  // Keep the last selected address for a stable q
  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= addr;
    end
  end

  assign ram_addr = cen ? addr_hold : addr;

  // Lower half, bits 26:0
  fpga_ram #(
    .width  (btb_bank_w),
    .addr_w (btb_idx_w)
  ) bank0 (
    .CLK  (CLK),
    .addr (ram_addr),
    .din  (d[btb_bank_w-1:0]),
    .we   (bank0_we),
    .dout (bank0_dout)
  );

  // Upper half, bits 53:27
  fpga_ram #(
    .width  (btb_bank_w),
    .addr_w (btb_idx_w)
  ) bank1 (
    .CLK  (CLK),
    .addr (ram_addr),
    .din  (d[btb_word_w-1:btb_bank_w]),
    .we   (bank1_we),
    .dout (bank1_dout)
  );

  assign q = {bank1_dout, bank0_dout};

endmodule

`default_nettype wire

//--- src/fpga_ram.sv
// Single-port synchronous RAM, one registered read port
// Read returns the old word when the same address is written
// No reset, contents are undefined at power-up
`timescale 1ns/100ps
`default_nettype none

module fpga_ram #(
  parameter int width  = 27,
  parameter int addr_w = 9
) (
  input  logic              CLK,
  input  logic [addr_w-1:0] addr,
  input  logic [width-1:0]  din,
  input  logic              we,
  output logic [width-1:0]  dout
);

  logic [width-1:0] mem [0:(1 << addr_w)-1];

  // Read every cycle, write on strobe
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

`default_nettype wire

//--- src/btb_pkg.sv
// Shared geometry, opcodes and entry layout of the branch target buffer
// Direct mapped, 512 entries, index is pc[10:2] and tag is pc[31:11]
// Pc bits 1:0 never take part in indexing or tag compare
`default_nettype none

package btb_pkg;

  // Geometry
  localparam int btb_idx_w  = 9;
  localparam int btb_depth  = 512;
  localparam int btb_pc_w   = 32;
  localparam int btb_tgt_w  = 32;
  localparam int btb_tag_w  = 21;
  localparam int btb_word_w = 54;
  localparam int btb_bank_w = 27;

  // Request opcodes, code 3 falls back to lookup
  localparam logic [1:0] op_lookup     = 2'd0;
  localparam logic [1:0] op_update     = 2'd1;
  localparam logic [1:0] op_invalidate = 2'd2;

  // Controller FSM encoding
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_access  = 2'd1;
  localparam logic [1:0] st_respond = 2'd2;
  localparam logic [1:0] st_wait    = 2'd3;

  // One SRAM word, seen as entry fields or as the two write banks
  typedef union packed {
    struct packed {
      logic                 valid;
      logic [btb_tag_w-1:0] tag;
      logic [btb_tgt_w-1:0] target;
    } fields;
    struct packed {
      logic [btb_bank_w-1:0] upper;
      logic [btb_bank_w-1:0] lower;
    } banks;
  } btb_entry_u;

endpackage

`default_nettype wire
